//--- include/udp_rx_consts.svh
`ifndef UDP_RX_CONSTS_SVH
`define UDP_RX_CONSTS_SVH

// preamble and start of frame
`define UDP_RX_PREAMBLE_BYTE 8'h55
`define UDP_RX_SFD 8'hd5
`define UDP_RX_MIN_PREAMBLE 16'd6
`define UDP_RX_MAX_PREAMBLE 16'd8

// header and trailer sizes in bytes
`define UDP_RX_ETH_HDR_BYTES 16'd14
`define UDP_RX_IP_HDR_BYTES 16'd20
`define UDP_RX_UDP_HDR_BYTES 16'd8
`define UDP_RX_FCS_BYTES 16'd4

// shortest payload before pad bytes are appended
`define UDP_RX_MIN_PAYLOAD 16'd18

// protocol fields
`define UDP_RX_ETHERTYPE_IPV4 16'h0800
`define UDP_RX_IP_VER 4'd4
`define UDP_RX_IP_IHL 4'd5
`define UDP_RX_BCAST_MAC 48'hffff_ffff_ffff

// crc-32, reflected form of 04c11db7
`define UDP_RX_CRC_RESIDUE_INIT 32'hffffffff
`define UDP_RX_CRC_POLY 32'hedb88320

`endif

//--- design/udp_rx_pkg.sv
package udp_rx_pkg;

  // one byte of the aligned receive stream
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       sof;
  } rx_byte_t;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] eth_type;
  } eth_hdr_t;

  // fields in wire order
  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] id;
    logic [15:0] flags_frag;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] checksum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ip_hdr_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] udp_len;
    logic [15:0] udp_sum;
  } udp_hdr_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } local_addr_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } peer_addr_t;

  typedef enum logic [3:0] {
    IDLE, PREAMBLE, ETH_HDR, IP_HDR, UDP_HDR, PAYLOAD, PAD, FCS, CHECK
  } rx_state_t;

endpackage

//--- design/gmii_rx_align.sv
`timescale 1ns/1ns

module gmii_rx_align (
  input  logic                 clk125M,
  input  logic                 reset_n,
  input  logic [7:0]           gmii_rxd,
  input  logic                 gmii_rxdv,
  output udp_rx_pkg::rx_byte_t stream
);

  logic [7:0]      rxd_q;
  logic            rxdv_q;
  logic [1:0][7:0] data_dly;
  logic [1:0]      valid_dly;
  logic [7:0]      data_q;
  logic            valid_q;
  logic            sof_q;

  // pin register
  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rxd_q  <= 8'h00;
      rxdv_q <= 1'b0;
    end
    else
    begin
      rxd_q  <= gmii_rxd;
      rxdv_q <= gmii_rxdv;
    end
  end

  always_ff @(posedge clk125M)
  begin
    data_dly <= {data_dly[0], rxd_q};
    data_q   <= data_dly[1];
  end

  // sof on the first valid byte after idle
  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
    begin
      valid_dly <= 2'b00;
      valid_q   <= 1'b0;
      sof_q     <= 1'b0;
    end
    else
    begin
      valid_dly <= {valid_dly[0], rxdv_q};
      valid_q   <= valid_dly[1];
      sof_q     <= valid_dly[1] & ~valid_q;
    end
  end

  assign stream = '{data: data_q, valid: valid_q, sof: sof_q};

endmodule

//--- design/hdr_shift.sv
`timescale 1ns/1ns

module hdr_shift #(
  parameter type hdr_t = logic [7:0]
) (
  input  logic                 clk125M,
  input  logic                 reset_n,
  input  udp_rx_pkg::rx_byte_t stream,
  input  logic                 cap,
  output hdr_t                 hdr
);

  localparam int W = $bits(hdr_t);

  logic [W-1:0] shreg;

  // first byte ends up in the top byte
  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
      shreg <= '0;
    else if (cap)
      shreg <= {shreg[W-9:0], stream.data};
  end

  assign hdr = hdr_t'(shreg);

endmodule

//--- design/ip_hdr_checksum.sv
`timescale 1ns/1ns

module ip_hdr_checksum (
  input  logic                 clk125M,
  input  logic                 reset_n,
  input  udp_rx_pkg::rx_byte_t stream,
  input  logic                 ip_cap,
  output logic                 csum_ok
);

  logic [15:0] sum;
  logic [7:0]  hi_byte;
  logic        odd;
  logic [16:0] add;

  // next 16-bit word joins the running sum
  assign add = {1'b0, sum} + {1'b0, hi_byte, stream.data};

  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
    begin
      sum     <= 16'h0000;
      hi_byte <= 8'h00;
      odd     <= 1'b0;
    end
    else if (stream.sof)
    begin
      sum <= 16'h0000;
      odd <= 1'b0;
    end
    else if (ip_cap)
    begin
      odd <= ~odd;
      if (!odd)
        hi_byte <= stream.data;
      else
        // end-around carry
        sum <= add[15:0] + {15'd0, add[16]};
    end
  end

  // a correct header folds to all ones
  assign csum_ok = (sum == 16'hffff);

endmodule

//--- design/crc32_d8.sv
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module crc32_d8 (
  input  logic                 clk125M,
  input  logic                 reset_n,
  input  udp_rx_pkg::rx_byte_t stream,
  input  logic                 crc_init,
  input  logic                 crc_en,
  output logic [31:0]          fcs_calc
);

  logic [31:0] crc;
  logic [31:0] crc_inv;

  // lsb first, one bit per step
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++)
    begin
      if (r[0] ^ d[i])
        r = (r >> 1) ^ `UDP_RX_CRC_POLY;
      else
        r = r >> 1;
    end
    return r;
  endfunction

  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
      crc <= `UDP_RX_CRC_RESIDUE_INIT;
    else if (crc_init)
      crc <= `UDP_RX_CRC_RESIDUE_INIT;
    else if (crc_en)
      crc <= crc_byte(crc, stream.data);
  end

  assign crc_inv = ~crc;

  // low byte goes on the wire first
  assign fcs_calc = {crc_inv[7:0], crc_inv[15:8], crc_inv[23:16], crc_inv[31:24]};

endmodule

//--- design/udp_rx_ctrl.sv
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module udp_rx_ctrl (
  input  logic                    clk125M,
  input  logic                    reset_n,
  input  udp_rx_pkg::rx_byte_t    stream,
  input  udp_rx_pkg::local_addr_t local_addr,
  input  logic                    fifo_full,
  input  udp_rx_pkg::eth_hdr_t    eth_hdr,
  input  udp_rx_pkg::ip_hdr_t     ip_hdr,
  input  udp_rx_pkg::udp_hdr_t    udp_hdr,
  input  logic                    csum_ok,
  input  logic [31:0]             fcs_calc,
  output logic                    eth_cap,
  output logic                    ip_cap,
  output logic                    udp_cap,
  output logic                    crc_init,
  output logic                    crc_en,
  output logic                    fifo_wr,
  output logic [7:0]              fifo_din,
  output udp_rx_pkg::peer_addr_t  peer,
  output logic [15:0]             rx_data_length,
  output logic                    pkt_done,
  output logic                    pkt_error
);
  import udp_rx_pkg::*;

  rx_state_t   state;
  rx_state_t   state_nxt;
  logic [15:0] cnt;
  logic [15:0] cnt_nxt;
  local_addr_t local_q;
  logic [31:0] fcs_rx;
  logic        full_flag;
  logic [15:0] data_len;
  udp_hdr_t    udp_full;
  logic        eth_ok;
  logic        ip_ok;
  logic        port_ok;

  ////////////////////////////////////////
  // filters
  assign data_len = ip_hdr.total_len - (`UDP_RX_IP_HDR_BYTES + `UDP_RX_UDP_HDR_BYTES);

  // udp header as it stands once the byte on the stream is shifted in
  assign udp_full = udp_hdr_t'({udp_hdr[$bits(udp_hdr_t)-9:0], stream.data});

  assign eth_ok = (eth_hdr.dst_mac == local_q.mac || eth_hdr.dst_mac == `UDP_RX_BCAST_MAC) &&
                  (eth_hdr.eth_type == `UDP_RX_ETHERTYPE_IPV4);

  assign ip_ok = (ip_hdr.ver == `UDP_RX_IP_VER) && (ip_hdr.ihl == `UDP_RX_IP_IHL) &&
                 csum_ok && (ip_hdr.dst_ip == local_q.ip);

  assign port_ok = (udp_full.dst_port == local_q.port);

  ////////////////////////////////////////
  // frame fsm
  always_comb
  begin
    state_nxt = state;
    cnt_nxt   = cnt + 16'd1;
    case (state)
      IDLE:
      begin
        cnt_nxt = 16'd1;
        if (stream.sof && stream.data == `UDP_RX_PREAMBLE_BYTE)
          state_nxt = PREAMBLE;
      end
      PREAMBLE:
      begin
        if (stream.data == `UDP_RX_SFD && cnt >= `UDP_RX_MIN_PREAMBLE)
        begin
          state_nxt = ETH_HDR;
          cnt_nxt   = 16'd0;
        end
        else if (stream.data != `UDP_RX_PREAMBLE_BYTE || cnt >= `UDP_RX_MAX_PREAMBLE)
          state_nxt = IDLE;
      end
      ETH_HDR:
      begin
        if (cnt == `UDP_RX_ETH_HDR_BYTES - 16'd1)
        begin
          state_nxt = IP_HDR;
          cnt_nxt   = 16'd0;
        end
      end
      IP_HDR:
      begin
        if (cnt == 16'd2 && !eth_ok)
          state_nxt = IDLE;
        else if (cnt == `UDP_RX_IP_HDR_BYTES - 16'd1)
        begin
          state_nxt = UDP_HDR;
          cnt_nxt   = 16'd0;
        end
      end
      UDP_HDR:
      begin
        if (cnt == 16'd2 && !ip_ok)
          state_nxt = IDLE;
        else if (cnt == `UDP_RX_UDP_HDR_BYTES - 16'd1)
        begin
          cnt_nxt = 16'd0;
          if (!port_ok)
            state_nxt = IDLE;
          else if (data_len == 16'd0)
            state_nxt = PAD;
          else
            state_nxt = PAYLOAD;
        end
      end
      PAYLOAD:
      begin
        // counter keeps running into PAD for short payloads
        if (cnt == data_len - 16'd1)
        begin
          if (data_len < `UDP_RX_MIN_PAYLOAD)
            state_nxt = PAD;
          else
          begin
            state_nxt = FCS;
            cnt_nxt   = 16'd0;
          end
        end
      end
      PAD:
      begin
        if (cnt >= `UDP_RX_MIN_PAYLOAD - 16'd1)
        begin
          state_nxt = FCS;
          cnt_nxt   = 16'd0;
        end
      end
      FCS:
      begin
        if (cnt == `UDP_RX_FCS_BYTES - 16'd1)
          state_nxt = CHECK;
      end
      CHECK:
        state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
    // frame ended early
    if (state != IDLE && state != CHECK && !stream.valid)
      state_nxt = IDLE;
  end

  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state <= IDLE;
      cnt   <= 16'd0;
    end
    else
    begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  assign eth_cap  = (state == ETH_HDR);
  assign ip_cap   = (state == IP_HDR);
  assign udp_cap  = (state == UDP_HDR);
  assign crc_init = (state == PREAMBLE) && (cnt == 16'd1);
  assign crc_en   = (state inside {ETH_HDR, IP_HDR, UDP_HDR, PAYLOAD, PAD});

  ////////////////////////////////////////
  // payload, fcs and result
  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
    begin
      local_q   <= '0;
      full_flag <= 1'b0;
      fifo_wr   <= 1'b0;
    end
    else
    begin
      if (state == IDLE)
        local_q <= local_addr;
      if (stream.sof)
        full_flag <= 1'b0;
      else if (state == PAYLOAD && fifo_full)
        full_flag <= 1'b1;
      fifo_wr <= (state == PAYLOAD) && stream.valid;
    end
  end

  always_ff @(posedge clk125M)
  begin
    fifo_din <= stream.data;
    if (state == FCS)
      fcs_rx <= {fcs_rx[23:0], stream.data};
  end

  always_ff @(posedge clk125M or negedge reset_n)
  begin
    if (!reset_n)
    begin
      pkt_done       <= 1'b0;
      pkt_error      <= 1'b0;
      peer           <= '0;
      rx_data_length <= 16'd0;
    end
    else
    begin
      pkt_done  <= (state == CHECK);
      pkt_error <= (state == CHECK) && ((fcs_rx != fcs_calc) || full_flag);
      if (state == CHECK)
      begin
        peer           <= '{mac: eth_hdr.src_mac, ip: ip_hdr.src_ip, port: udp_hdr.src_port};
        rx_data_length <= data_len;
      end
    end
  end

endmodule

//--- design/udp_rx_top.sv
`timescale 1ns/1ns

module udp_rx_top (
  input  logic                    clk125M,
  input  logic                    reset_n,
  input  logic [7:0]              gmii_rxd,
  input  logic                    gmii_rxdv,
  input  udp_rx_pkg::local_addr_t local_addr,
  input  logic                    fifo_full,
  output logic                    fifo_wr,
  output logic [7:0]              fifo_din,
  output udp_rx_pkg::peer_addr_t  peer,
  output logic [15:0]             rx_data_length,
  output logic                    pkt_done,
  output logic                    pkt_error
);
  import udp_rx_pkg::*;

  rx_byte_t    stream;
  eth_hdr_t    eth_hdr;
  ip_hdr_t     ip_hdr;
  udp_hdr_t    udp_hdr;
  logic        eth_cap;
  logic        ip_cap;
  logic        udp_cap;
  logic        csum_ok;
  logic        crc_init;
  logic        crc_en;
  logic [31:0] fcs_calc;

  gmii_rx_align u_align (.clk125M, .reset_n, .gmii_rxd, .gmii_rxdv, .stream);

  ////////////////////////////////////////
  // header capture
  hdr_shift #(.hdr_t(eth_hdr_t)) u_eth_cap (
    .clk125M, .reset_n, .stream, .cap(eth_cap), .hdr(eth_hdr)
  );

  hdr_shift #(.hdr_t(ip_hdr_t)) u_ip_cap (
    .clk125M, .reset_n, .stream, .cap(ip_cap), .hdr(ip_hdr)
  );

  hdr_shift #(.hdr_t(udp_hdr_t)) u_udp_cap (
    .clk125M, .reset_n, .stream, .cap(udp_cap), .hdr(udp_hdr)
  );

  ////////////////////////////////////////
  // checks on the byte stream
  ip_hdr_checksum u_csum (.clk125M, .reset_n, .stream, .ip_cap, .csum_ok);

  crc32_d8 u_crc (.clk125M, .reset_n, .stream, .crc_init, .crc_en, .fcs_calc);

  udp_rx_ctrl u_ctrl (
    .clk125M, .reset_n, .stream, .local_addr, .fifo_full,
    .eth_hdr, .ip_hdr, .udp_hdr, .csum_ok, .fcs_calc,
    .eth_cap, .ip_cap, .udp_cap, .crc_init, .crc_en,
    .fifo_wr, .fifo_din, .peer, .rx_data_length, .pkt_done, .pkt_error
  );

endmodule

//--- testbench/udp_rx_props.sv
`timescale 1ns/1ns

module udp_rx_props (
  input logic                   clk125M,
  input logic                   reset_n,
  input logic                   fifo_wr,
  input logic                   pkt_done,
  input logic                   pkt_error,
  input udp_rx_pkg::peer_addr_t peer,
  input logic [15:0]            rx_data_length
);

  int unsigned fail_count = 0;

  done_single: assert property (@(posedge clk125M) disable iff (!reset_n)
    pkt_done |=> !pkt_done)
  else
  begin
    $error("pkt_done high on two consecutive cycles");
    fail_count++;
  end

  // error only qualifies a done
  error_with_done: assert property (@(posedge clk125M) disable iff (!reset_n)
    pkt_error |-> pkt_done)
  else
  begin
    $error("pkt_error high without pkt_done");
    fail_count++;
  end

  no_write_at_done: assert property (@(posedge clk125M) disable iff (!reset_n)
    pkt_done |-> !fifo_wr)
  else
  begin
    $error("fifo_wr high in the pkt_done cycle");
    fail_count++;
  end

  quiet_in_reset: assert property (@(posedge clk125M)
    !reset_n |-> !fifo_wr && !pkt_done && !pkt_error && peer == '0 && rx_data_length == 16'd0)
  else
  begin
    $error("output active while reset_n is low");
    fail_count++;
  end

endmodule

bind udp_rx_top udp_rx_props u_props (
  .clk125M, .reset_n, .fifo_wr, .pkt_done, .pkt_error, .peer, .rx_data_length
);

//--- testbench/tb_udp_rx.sv
`timescale 1ns/1ns
`include "udp_rx_consts.svh"

module tb_udp_rx;
  import udp_rx_pkg::*;

  localparam int FRAME_CYCLES = 130;
  localparam int NUM_FRAMES   = 9;
  localparam int MAX_CYCLES   = NUM_FRAMES * FRAME_CYCLES + 200;

  localparam logic [47:0] LOCAL_MAC  = 48'h02_00_00_00_00_01;
  localparam logic [31:0] LOCAL_IP   = 32'hc0a8_0102;
  localparam logic [15:0] LOCAL_PORT = 16'd5000;
  localparam logic [47:0] SRC_MAC    = 48'h02_aa_bb_cc_dd_ee;
  localparam logic [31:0] SRC_IP     = 32'hc0a8_0101;
  localparam logic [15:0] SRC_PORT   = 16'h1234;

  logic        clk125M;
  logic        reset_n;
  logic [7:0]  gmii_rxd;
  logic        gmii_rxdv;
  local_addr_t local_addr;
  logic        fifo_full;
  logic        fifo_wr;
  logic [7:0]  fifo_din;
  peer_addr_t  peer;
  logic [15:0] rx_data_length;
  logic        pkt_done;
  logic        pkt_error;

  logic [31:0] lfsr;
  logic [7:0]  frame[$];
  logic [7:0]  exp_bytes[$];
  logic        done_expected;
  logic        exp_error;
  peer_addr_t  exp_peer;
  logic [15:0] exp_length;
  int          cycles = 0;
  string       test_name;

  udp_rx_top u_dut (
    .clk125M, .reset_n, .gmii_rxd, .gmii_rxdv, .local_addr, .fifo_full,
    .fifo_wr, .fifo_din, .peer, .rx_data_length, .pkt_done, .pkt_error
  );

  initial clk125M = 1'b0;
  always #4 clk125M = ~clk125M;

  ////////////////////////////////////////
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string field, input logic [95:0] exp, input logic [95:0] act);
    assert (act === exp)
    else
      abort_run($sformatf("Fail %s %s expected %0h actual %0h", test_name, field, exp, act));
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  // one step per bit, lsb first
  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
    return b;
  endfunction

  // reflected crc-32 over frame[first..last]
  function automatic logic [31:0] frame_fcs(input int first, input int last);
    logic [31:0] c;
    c = 32'hffff_ffff;
    for (int n = first; n <= last; n++)
      for (int i = 0; i < 8; i++)
        c = (c[0] ^ frame[n][i]) ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
    return ~c;
  endfunction

  function automatic logic [15:0] ip_checksum(input int first);
    logic [31:0] s;
    s = 32'd0;
    for (int n = 0; n < 20; n += 2)
      s += {frame[first+n], frame[first+n+1]};
    s = s[15:0] + s[31:16];
    s = s[15:0] + s[31:16];
    return ~s[15:0];
  endfunction

  task automatic push_field(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--)
      frame.push_back(v[i*8 +: 8]);
  endtask

  task automatic build_frame(input logic [47:0] dst_mac, input logic [15:0] eth_type,
                             input logic [31:0] dst_ip, input logic [15:0] dst_port,
                             input int len, input logic bad_csum, input logic bad_fcs,
                             input logic accept);
    logic [7:0]  b;
    logic [15:0] csum;
    logic [31:0] fcs;
    int          ip_start;
    frame.delete();
    repeat (7) frame.push_back(`UDP_RX_PREAMBLE_BYTE);
    frame.push_back(`UDP_RX_SFD);
    push_field(dst_mac, 6);
    push_field(SRC_MAC, 6);
    push_field(eth_type, 2);
    ip_start = frame.size();
    push_field({4'd4, 4'd5, 8'h00}, 2);
    push_field(16'(len + 28), 2);
    push_field(16'h1c46, 2);
    push_field(16'h4000, 2);
    // ttl 64 and protocol udp
    push_field({8'h40, 8'h11}, 2);
    push_field(16'h0000, 2);
    push_field(SRC_IP, 4);
    push_field(dst_ip, 4);
    csum = ip_checksum(ip_start) ^ {15'd0, bad_csum};
    frame[ip_start+10] = csum[15:8];
    frame[ip_start+11] = csum[7:0];
    push_field(SRC_PORT, 2);
    push_field(dst_port, 2);
    push_field(16'(len + 8), 2);
    push_field(16'h0000, 2);
    for (int i = 0; i < len; i++)
    begin
      b = random_byte();
      frame.push_back(b);
      if (accept)
        exp_bytes.push_back(b);
    end
    for (int i = len; i < `UDP_RX_MIN_PAYLOAD; i++)
      frame.push_back(8'h00);
    fcs = frame_fcs(8, frame.size() - 1) ^ {31'd0, bad_fcs};
    // fcs low byte first on the wire
    for (int i = 0; i < 4; i++)
      frame.push_back(fcs[i*8 +: 8]);
  endtask

  task automatic send_frame(input int full_first, input int full_last);
    for (int i = 0; i < frame.size(); i++)
    begin
      @(negedge clk125M);
      gmii_rxd  = frame[i];
      gmii_rxdv = 1'b1;
      fifo_full = (i >= full_first) && (i <= full_last);
    end
    @(negedge clk125M);
    gmii_rxd  = 8'h00;
    gmii_rxdv = 1'b0;
    fifo_full = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk125M);
  endtask

  task automatic wait_done();
    while (done_expected)
      @(negedge clk125M);
  endtask

  // a full window, when given, lies inside the payload
  task automatic run_accepted(input string name, input logic [47:0] dst_mac, input int len,
                              input logic bad_fcs, input int full_first, input int full_last);
    test_name = name;
    build_frame(dst_mac, `UDP_RX_ETHERTYPE_IPV4, LOCAL_IP, LOCAL_PORT, len, 1'b0, bad_fcs, 1'b1);
    exp_error     = bad_fcs || (full_first <= full_last);
    exp_peer      = '{mac: SRC_MAC, ip: SRC_IP, port: SRC_PORT};
    exp_length    = 16'(len);
    done_expected = 1'b1;
    send_frame(full_first, full_last);
    wait_done();
    check_value("payload bytes missing", 96'd0, 96'(exp_bytes.size()));
    idle(8);
  endtask

  task automatic run_rejected(input string name, input logic [15:0] eth_type,
                              input logic [31:0] dst_ip, input logic [15:0] dst_port,
                              input logic bad_csum);
    test_name = name;
    build_frame(LOCAL_MAC, eth_type, dst_ip, dst_port, 12, bad_csum, 1'b0, 1'b0);
    send_frame(-1, -2);
    idle(16);
  endtask

  ////////////////////////////////////////
  // output checker

  always @(negedge clk125M)
  begin
    if (reset_n)
    begin
      if (fifo_wr)
      begin
        if (exp_bytes.size() == 0)
          abort_run($sformatf("%s: payload byte written that was not expected", test_name));
        else
          check_value("fifo_din", exp_bytes.pop_front(), fifo_din);
      end
      if (pkt_done)
      begin
        if (!done_expected)
          abort_run($sformatf("%s: pkt_done fired for a frame that should be dropped", test_name));
        else
        begin
          check_value("pkt_error", exp_error, pkt_error);
          check_value("peer", exp_peer, peer);
          check_value("rx_data_length", exp_length, rx_data_length);
          done_expected = 1'b0;
        end
      end
      if (u_dut.u_props.fail_count != 0)
        abort_run("an assertion on the DUT outputs failed");
    end
  end

  always @(posedge clk125M)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      abort_run("timeout: the frames did not finish within the cycle limit");
  end

  ////////////////////////////////////////
  // stimulus

  initial
  begin
    lfsr          = 32'h5230;
    reset_n       = 1'b1;
    gmii_rxd      = 8'h00;
    gmii_rxdv     = 1'b0;
    fifo_full     = 1'b0;
    local_addr    = '{mac: LOCAL_MAC, ip: LOCAL_IP, port: LOCAL_PORT};
    done_expected = 1'b0;
    exp_error     = 1'b0;
    exp_peer      = '0;
    exp_length    = 16'd0;
    test_name     = "after_reset";
    // a real falling edge on reset_n before the first clock
    #1;
    reset_n = 1'b0;
    repeat (3) @(negedge clk125M);
    reset_n = 1'b1;
    idle(2);
    check_value("fifo_wr", 96'd0, fifo_wr);
    check_value("pkt_done", 96'd0, pkt_done);
    check_value("pkt_error", 96'd0, pkt_error);
    check_value("peer", 96'd0, peer);
    check_value("rx_data_length", 96'd0, rx_data_length);

    run_accepted("unicast_40", LOCAL_MAC, 40, 1'b0, -1, -2);
    run_accepted("broadcast_5", `UDP_RX_BCAST_MAC, 5, 1'b0, -1, -2);
    run_accepted("bad_fcs", LOCAL_MAC, 24, 1'b1, -1, -2);

    run_rejected("wrong_ethertype", 16'h86dd, LOCAL_IP, LOCAL_PORT, 1'b0);
    run_rejected("wrong_dst_ip", `UDP_RX_ETHERTYPE_IPV4, LOCAL_IP + 32'd1, LOCAL_PORT, 1'b0);
    run_rejected("bad_ip_checksum", `UDP_RX_ETHERTYPE_IPV4, LOCAL_IP, LOCAL_PORT, 1'b1);
    run_rejected("wrong_port", `UDP_RX_ETHERTYPE_IPV4, LOCAL_IP, LOCAL_PORT + 16'd1, 1'b0);

    // payload starts at frame byte 50
    run_accepted("fifo_full", LOCAL_MAC, 30, 1'b0, 55, 58);
    run_accepted("after_fifo_full", LOCAL_MAC, 30, 1'b0, -1, -2);
    idle(4);

    if (u_dut.u_props.fail_count != 0)
      abort_run("an assertion on the DUT outputs failed");
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- udp_rx.f
+incdir+include
design/udp_rx_pkg.sv
design/gmii_rx_align.sv
design/hdr_shift.sv
design/ip_hdr_checksum.sv
design/crc32_d8.sv
design/udp_rx_ctrl.sv
design/udp_rx_top.sv
testbench/udp_rx_props.sv
testbench/tb_udp_rx.sv
